//--- logic/axil_mem_pkg.sv
// ----------------------------------------------------------
// Shared definitions of the AXI4-Lite to split memory bridge.
// Widths, depth of the read buffer, vector typedefs,
// packed AXI-Lite and memory channel structs, write states.
// ----------------------------------------------------------
`default_nettype none

package axil_mem_pkg;

  // Byte address and data widths.
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Reads in flight, also the response buffer depth.
  localparam int unsigned RD_BUF_DEPTH = 2;
  // Wide enough to hold 0 up to RD_BUF_DEPTH.
  localparam int unsigned CNT_W = $clog2(RD_BUF_DEPTH + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Master driven AXI-Lite signals.
  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axil_req_t;

  // Slave driven AXI-Lite signals.
  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic [1:0] b_resp;
    logic       b_valid;
    logic       ar_ready;
    data_t      r_data;
    logic [1:0] r_resp;
    logic       r_valid;
  } axil_rsp_t;

  // One memory request, req/gnt handshake.
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  // One memory response, rvalid marks the answer.
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

  // Write path states.
  typedef enum logic [1:0] {
    WR_IDLE = 2'b00,
    WR_REQ  = 2'b01,
    WR_WAIT = 2'b10,
    WR_RESP = 2'b11
  } wr_state_e;

endpackage

`default_nettype wire

//--- logic/rsp_fifo.sv
// ----------------------------------------------------------
// Read response FIFO of RD_BUF_DEPTH entries.
// Register array with read and write pointers,
// push and pop allowed in the same cycle.
// ----------------------------------------------------------
`default_nettype none

module rsp_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  axil_mem_pkg::data_t push_data_i,
  input  logic                pop_i,
  output axil_mem_pkg::data_t pop_data_o,
  output logic                valid_o,
  output axil_mem_pkg::cnt_t  fill_o
);
  import axil_mem_pkg::*;

  // Storage, payload only.
  data_t                           mem_q [RD_BUF_DEPTH];
  logic [$clog2(RD_BUF_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(RD_BUF_DEPTH)-1:0] rd_ptr_q;
  cnt_t                            fill_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at the last entry.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == RD_BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == RD_BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together keep the fill level.
      if (push_i && !pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop_i && !push_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // Head entry is visible while not empty.
  assign pop_data_o = mem_q[rd_ptr_q];
  assign valid_o    = (fill_q != '0);
  assign fill_o     = fill_q;

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (fill_q != '0))
    else $error("rsp_fifo popped while empty");

endmodule

`default_nettype wire

//--- logic/pending_counter.sv
// ----------------------------------------------------------
// Count of granted memory reads not yet answered.
// Up on grant, down on rvalid.
// ----------------------------------------------------------
`default_nettype none

module pending_counter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               inc_i,
  input  logic               dec_i,
  output axil_mem_pkg::cnt_t count_o
);
  import axil_mem_pkg::*;

  cnt_t count_q;

  // Grant and rvalid together leave the count unchanged.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (inc_i && !dec_i) begin
      count_q <= count_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count_o = count_q;

  // An answer needs an earlier grant.
  a_no_dec_zero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_i |-> (count_q != '0))
    else $error("pending_counter decremented at zero");

  // Credit check upstream keeps the count bounded.
  a_no_inc_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inc_i |-> (count_q != RD_BUF_DEPTH))
    else $error("pending_counter incremented at RD_BUF_DEPTH");

endmodule

`default_nettype wire

//--- logic/write_fsm.sv
// ----------------------------------------------------------
// Write path, one AXI-Lite write at a time.
// Takes AW and W together, issues the write on the
// write memory port and returns the B response.
// Zero strobe writes skip memory.
// ----------------------------------------------------------
`default_nettype none

module write_fsm (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axil_mem_pkg::addr_t    aw_addr_i,
  input  logic                   aw_valid_i,
  input  axil_mem_pkg::data_t    w_data_i,
  input  axil_mem_pkg::strb_t    w_strb_i,
  input  logic                   w_valid_i,
  input  logic                   b_ready_i,
  output logic                   aw_ready_o,
  output logic                   w_ready_o,
  output logic                   b_valid_o,
  output logic [1:0]             b_resp_o,
  output axil_mem_pkg::mem_req_t mem_req_o,
  input  axil_mem_pkg::mem_rsp_t mem_rsp_i,
  output logic                   busy_o
);
  import axil_mem_pkg::*;

  wr_state_e state_q, state_d;
  addr_t     addr_q;
  data_t     data_q;
  strb_t     strb_q;
  logic      accept;

  // Both channels transfer in the same cycle.
  assign accept     = (state_q == WR_IDLE) && aw_valid_i && w_valid_i;
  assign aw_ready_o = accept;
  assign w_ready_o  = accept;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WR_IDLE: begin
        if (accept) begin
          state_d = (w_strb_i != '0) ? WR_REQ : WR_RESP;
        end
      end
      // Hold the request until granted.
      WR_REQ:  if (mem_rsp_i.gnt)    state_d = WR_WAIT;
      WR_WAIT: if (mem_rsp_i.rvalid) state_d = WR_RESP;
      // B back-pressure blocks new writes.
      WR_RESP: if (b_ready_i)        state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Write payload, captured on the AW/W transfer.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= aw_addr_i;
      data_q <= w_data_i;
      strb_q <= w_strb_i;
    end
  end

  assign mem_req_o.req   = (state_q == WR_REQ);
  assign mem_req_o.we    = 1'b1;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = data_q;
  assign mem_req_o.strb  = strb_q;

  // Always OKAY.
  assign b_valid_o = (state_q == WR_RESP);
  assign b_resp_o  = 2'b00;
  assign busy_o    = (state_q != WR_IDLE);

  a_rvalid_in_wait : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> (state_q == WR_WAIT))
    else $error("write_fsm got rvalid outside WR_WAIT");

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_o.req && !mem_rsp_i.gnt) |=> $stable(mem_req_o))
    else $error("write_fsm changed an ungranted memory request");

endmodule

`default_nettype wire

//--- logic/read_port.sv
// ----------------------------------------------------------
// Read path with up to RD_BUF_DEPTH reads in flight.
// AR goes straight to memory when credit is left,
// responses wait in the FIFO until R is taken.
// ----------------------------------------------------------
`default_nettype none

module read_port (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axil_mem_pkg::addr_t    ar_addr_i,
  input  logic                   ar_valid_i,
  input  logic                   r_ready_i,
  output logic                   ar_ready_o,
  output logic                   r_valid_o,
  output axil_mem_pkg::data_t    r_data_o,
  output logic [1:0]             r_resp_o,
  output axil_mem_pkg::mem_req_t mem_req_o,
  input  axil_mem_pkg::mem_rsp_t mem_rsp_i,
  output logic                   busy_o
);
  import axil_mem_pkg::*;

  cnt_t         pending;
  cnt_t         fill;
  logic [CNT_W:0] in_use;
  logic         credit;
  logic         granted;
  logic         pop;

  // Reads in flight plus buffered answers.
  assign in_use = pending + fill;
  assign credit = (in_use < RD_BUF_DEPTH);

  // Address passes through, AR and grant share one cycle.
  assign mem_req_o.req   = ar_valid_i && credit;
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.addr  = ar_addr_i;
  assign mem_req_o.wdata = '0;
  assign mem_req_o.strb  = '0;
  assign ar_ready_o      = mem_rsp_i.gnt && credit;

  assign granted = mem_req_o.req && mem_rsp_i.gnt;
  assign pop     = r_valid_o && r_ready_i;

  pending_counter i_pending_counter (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .inc_i   ( granted          ),
    .dec_i   ( mem_rsp_i.rvalid ),
    .count_o ( pending          )
  );

  rsp_fifo i_rsp_fifo (
    .clk_i       ( clk_i            ),
    .rst_n_i     ( rst_n_i          ),
    .push_i      ( mem_rsp_i.rvalid ),
    .push_data_i ( mem_rsp_i.rdata  ),
    .pop_i       ( pop              ),
    .pop_data_o  ( r_data_o         ),
    .valid_o     ( r_valid_o        ),
    .fill_o      ( fill             )
  );

  // Always OKAY.
  assign r_resp_o = 2'b00;
  assign busy_o   = (in_use != '0);

  // Credit reserves a FIFO slot for every granted read.
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> (fill != RD_BUF_DEPTH))
    else $error("read_port pushed into a full response FIFO");

endmodule

`default_nettype wire

//--- logic/axil_to_mem_split.sv
// ----------------------------------------------------------
// AXI4-Lite slave with separate read and write memory ports.
// Routes the AXI-Lite bundle to the read and write paths
// and merges their busy flags.
// ----------------------------------------------------------
`default_nettype none

module axil_to_mem_split (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  axil_mem_pkg::axil_req_t axil_req_i,
  output axil_mem_pkg::axil_rsp_t axil_rsp_o,
  output axil_mem_pkg::mem_req_t  rd_mem_req_o,
  input  axil_mem_pkg::mem_rsp_t  rd_mem_rsp_i,
  output axil_mem_pkg::mem_req_t  wr_mem_req_o,
  input  axil_mem_pkg::mem_rsp_t  wr_mem_rsp_i,
  output logic                    busy_o
);

  logic rd_busy;
  logic wr_busy;

  // AW, W and B channels.
  write_fsm i_write_fsm (
    .clk_i      ( clk_i               ),
    .rst_n_i    ( rst_n_i             ),
    .aw_addr_i  ( axil_req_i.aw_addr  ),
    .aw_valid_i ( axil_req_i.aw_valid ),
    .w_data_i   ( axil_req_i.w_data   ),
    .w_strb_i   ( axil_req_i.w_strb   ),
    .w_valid_i  ( axil_req_i.w_valid  ),
    .b_ready_i  ( axil_req_i.b_ready  ),
    .aw_ready_o ( axil_rsp_o.aw_ready ),
    .w_ready_o  ( axil_rsp_o.w_ready  ),
    .b_valid_o  ( axil_rsp_o.b_valid  ),
    .b_resp_o   ( axil_rsp_o.b_resp   ),
    .mem_req_o  ( wr_mem_req_o        ),
    .mem_rsp_i  ( wr_mem_rsp_i        ),
    .busy_o     ( wr_busy             )
  );

  // AR and R channels.
  read_port i_read_port (
    .clk_i      ( clk_i               ),
    .rst_n_i    ( rst_n_i             ),
    .ar_addr_i  ( axil_req_i.ar_addr  ),
    .ar_valid_i ( axil_req_i.ar_valid ),
    .r_ready_i  ( axil_req_i.r_ready  ),
    .ar_ready_o ( axil_rsp_o.ar_ready ),
    .r_valid_o  ( axil_rsp_o.r_valid  ),
    .r_data_o   ( axil_rsp_o.r_data   ),
    .r_resp_o   ( axil_rsp_o.r_resp   ),
    .mem_req_o  ( rd_mem_req_o        ),
    .mem_rsp_i  ( rd_mem_rsp_i        ),
    .busy_o     ( rd_busy             )
  );

  // Busy while either path has work.
  assign busy_o = rd_busy || wr_busy;

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
// ----------------------------------------------------------
// Behavioral memory for one req/gnt memory port.
// Random grant stalls, random in-order response delay,
// storage shared through the testbench top.
// ----------------------------------------------------------
`default_nettype none

module tb_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axil_mem_pkg::mem_req_t req_i,
  output axil_mem_pkg::mem_rsp_t rsp_o,
  output logic                   idle_o
);
  import axil_mem_pkg::*;

  // Answers waiting for their due cycle, oldest first.
  data_t rdata_q [$];
  int    due_q [$];
  int    cycle;
  int    n_q;
  int    b;
  data_t word;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_o <= '0;
      n_q   <= 0;
      cycle = 0;
      rdata_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      // A granted request reads or merges the word now.
      if (req_i.req && rsp_o.gnt) begin
        word = tb_axil_to_mem_split.storage[req_i.addr[ADDR_W-1:2]];
        if (req_i.we) begin
          for (b = 0; b < STRB_W; b++) begin
            if (req_i.strb[b]) word[8*b +: 8] = req_i.wdata[8*b +: 8];
          end
          tb_axil_to_mem_split.storage[req_i.addr[ADDR_W-1:2]] = word;
        end
        rdata_q.push_back(word);
        due_q.push_back(cycle + $urandom_range(0, 3));
      end
      // Earliest answer shows in the cycle after the grant.
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        rsp_o.rvalid <= 1'b1;
        rsp_o.rdata  <= rdata_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        rsp_o.rvalid <= 1'b0;
      end
      // Stall about one cycle in four.
      rsp_o.gnt <= ($urandom_range(0, 3) != 0);
      n_q       <= due_q.size();
    end
  end

  assign idle_o = (n_q == 0) && !rsp_o.rvalid;

endmodule

`default_nettype wire

//--- test/tb_axil_to_mem_split.sv
// ----------------------------------------------------------
// Testbench of the AXI4-Lite split memory bridge.
// Clock, reset, AXI-Lite stimulus, two memory models,
// shadow memory with a reference function, R checker.
// ----------------------------------------------------------
`default_nettype none

module tb_axil_to_mem_split;
  import axil_mem_pkg::*;

  localparam int WORDS   = 2 ** (ADDR_W - 2);
  localparam int TIMEOUT = 200;

  logic      clk_i;
  logic      rst_n_i;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  mem_req_t  rd_mem_req;
  mem_rsp_t  rd_mem_rsp;
  mem_req_t  wr_mem_req;
  mem_rsp_t  wr_mem_rsp;
  logic      busy;
  logic      rd_idle;
  logic      wr_idle;
  logic      zero_strb_wr;
  int        rd_grants;
  int        base;
  int        t;
  addr_t     addrs [8];

  // Memory seen by both models and the expected contents.
  data_t storage [WORDS];
  data_t shadow  [WORDS];
  // Expected R data in AR order.
  data_t exp_q [$];

  axil_to_mem_split i_dut (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .axil_req_i   ( axil_req   ),
    .axil_rsp_o   ( axil_rsp   ),
    .rd_mem_req_o ( rd_mem_req ),
    .rd_mem_rsp_i ( rd_mem_rsp ),
    .wr_mem_req_o ( wr_mem_req ),
    .wr_mem_rsp_i ( wr_mem_rsp ),
    .busy_o       ( busy       )
  );

  tb_mem_model i_rd_mem (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .req_i   ( rd_mem_req ),
    .rsp_o   ( rd_mem_rsp ),
    .idle_o  ( rd_idle    )
  );

  tb_mem_model i_wr_mem (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .req_i   ( wr_mem_req ),
    .rsp_o   ( wr_mem_rsp ),
    .idle_o  ( wr_idle    )
  );

  always #2 clk_i = ~clk_i;

  // Initial contents depend on the whole word index.
  function automatic data_t fill_word(input int idx);
    return (data_t'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  // Bytes with a set strobe bit take the new value.
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
    data_t res;
    res = old_w;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // Reference read word.
  function automatic data_t expected_read(input addr_t addr);
    return shadow[addr[ADDR_W-1:2]];
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  // Send AW and W together and wait for B.
  task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb);
    int n;
    @(posedge clk_i);
    shadow[addr[ADDR_W-1:2]] = merge_bytes(shadow[addr[ADDR_W-1:2]], data, strb);
    zero_strb_wr = (strb == '0);
    axil_req.aw_addr  <= addr;
    axil_req.aw_valid <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= strb;
    axil_req.w_valid  <= 1'b1;
    n = 0;
    @(posedge clk_i);
    while (!axil_rsp.aw_ready) begin
      assert (!axil_rsp.w_ready)
        else stop_on_error("w_ready rose without aw_ready");
      n++;
      assert (n < TIMEOUT) else stop_on_error("write was not accepted in time");
      @(posedge clk_i);
    end
    // AW and W transfer in the same cycle.
    assert (axil_rsp.w_ready)
      else stop_on_error($sformatf("[FAIL] w_ready expected %h got %h",
                                   1'b1, axil_rsp.w_ready));
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    n = 0;
    while (!axil_rsp.b_valid) begin
      n++;
      assert (n < TIMEOUT) else stop_on_error("no B response arrived in time");
      @(posedge clk_i);
    end
    assert (axil_rsp.b_resp == 2'b00)
      else stop_on_error($sformatf("[FAIL] b_resp expected %h got %h",
                                   2'b00, axil_rsp.b_resp));
    assert (busy) else stop_on_error("busy_o was low while a B response was pending");
    zero_strb_wr = 1'b0;
  endtask

  // Expected data is queued when AR is taken.
  task automatic axil_read(input addr_t addr);
    int n;
    @(posedge clk_i);
    axil_req.ar_addr  <= addr;
    axil_req.ar_valid <= 1'b1;
    n = 0;
    @(posedge clk_i);
    while (!axil_rsp.ar_ready) begin
      n++;
      assert (n < TIMEOUT) else stop_on_error("read was not accepted in time");
      @(posedge clk_i);
    end
    exp_q.push_back(expected_read(addr));
    axil_req.ar_valid <= 1'b0;
  endtask

  // All R beats taken and both memories quiet.
  task automatic drain_responses();
    int n;
    n = 0;
    while (exp_q.size() != 0 || !rd_idle || !wr_idle || axil_rsp.r_valid) begin
      n++;
      assert (n < TIMEOUT) else stop_on_error("read responses did not drain in time");
      @(posedge clk_i);
    end
  endtask

  // R checker against the reference.
  always @(posedge clk_i) begin
    if (rst_n_i && axil_rsp.r_valid && axil_req.r_ready) begin
      assert (exp_q.size() != 0) else stop_on_error("R beat arrived with no read outstanding");
      assert (axil_rsp.r_data == exp_q[0])
        else stop_on_error($sformatf("[FAIL] r_data expected %h got %h",
                                     exp_q[0], axil_rsp.r_data));
      assert (axil_rsp.r_resp == 2'b00)
        else stop_on_error($sformatf("[FAIL] r_resp expected %h got %h",
                                     2'b00, axil_rsp.r_resp));
      assert (busy) else stop_on_error("busy_o was low while an R beat was pending");
      void'(exp_q.pop_front());
    end
  end

  // Port separation and the zero strobe rule.
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (rd_mem_req.req && rd_mem_rsp.gnt) rd_grants <= rd_grants + 1;
      assert (!rd_mem_req.req || !rd_mem_req.we)
        else stop_on_error("write request seen on the read memory port");
      assert (!wr_mem_req.req || wr_mem_req.we)
        else stop_on_error("read request seen on the write memory port");
      assert (!(zero_strb_wr && wr_mem_req.req))
        else stop_on_error("zero strobe write reached the write memory port");
    end
  end

  initial begin
    void'($urandom(32'hcae5ab45));
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    axil_req         = '0;
    axil_req.b_ready = 1'b1;
    axil_req.r_ready = 1'b1;
    zero_strb_wr     = 1'b0;
    rd_grants        = 0;
    for (int i = 0; i < WORDS; i++) begin
      storage[i] = fill_word(i);
      shadow[i]  = fill_word(i);
    end
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    #1;
    assert (!axil_rsp.aw_ready && !axil_rsp.w_ready && !axil_rsp.b_valid &&
            !axil_rsp.ar_ready && !axil_rsp.r_valid && !rd_mem_req.req &&
            !wr_mem_req.req && !busy)
      else stop_on_error("a ready, valid, req or busy output was high after reset");

    // Random strobe writes followed by reads of the same words.
    for (int i = 0; i < 8; i++) begin
      addrs[i] = addr_t'($urandom_range(0, 1023) << 2);
      axil_write(addrs[i], $urandom, strb_t'($urandom_range(1, 15)));
    end
    for (int i = 0; i < 8; i++) axil_read(addrs[i]);
    drain_responses();

    // Zero strobe leaves the word alone.
    axil_write(16'h0800, 32'h1234_5678, 4'hf);
    axil_write(16'h0800, 32'hdead_beef, 4'h0);
    axil_read(16'h0800);
    drain_responses();

    // R back-pressure limits the reads in flight.
    base = rd_grants;
    axil_req.r_ready <= 1'b0;
    fork
      for (int i = 0; i < 4; i++) axil_read(addr_t'(16'h0c00 + 4 * i));
      begin
        t = 0;
        while (rd_grants - base < RD_BUF_DEPTH) begin
          t++;
          assert (t < TIMEOUT) else stop_on_error("reads were not granted in time");
          @(posedge clk_i);
        end
        repeat (20) @(posedge clk_i);
        assert (rd_grants - base == RD_BUF_DEPTH)
          else stop_on_error($sformatf("[FAIL] rd_grants expected %h got %h",
                                       RD_BUF_DEPTH, rd_grants - base));
        axil_req.r_ready <= 1'b1;
      end
    join
    drain_responses();

    // Reads and writes at once on separate address ranges.
    fork
      for (int i = 0; i < 6; i++) begin
        axil_write(addr_t'(16'h1000 + 4 * i), $urandom, strb_t'($urandom_range(1, 15)));
      end
      for (int i = 0; i < 6; i++) axil_read(addr_t'(16'h2000 + 4 * i));
    join
    for (int i = 0; i < 6; i++) axil_read(addr_t'(16'h1000 + 4 * i));
    drain_responses();

    // With nothing left the bridge is idle.
    assert (!busy) else stop_on_error("busy_o stayed high with no work left");
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
logic/axil_mem_pkg.sv
logic/rsp_fifo.sv
logic/pending_counter.sv
logic/write_fsm.sv
logic/read_port.sv
logic/axil_to_mem_split.sv
test/tb_mem_model.sv
test/tb_axil_to_mem_split.sv
